// ==== ethRt_macros.svh ====
// Constants for the real-time Ethernet shim
// CRC values assume the reflected (LSB-first) IEEE 802.3 polynomial
// Register addresses are byte offsets within a 16-byte APB window
`ifndef ETH_RT_MACROS_SVH
`define ETH_RT_MACROS_SVH

// Framing
`define ETH_PREAMBLE_LEN   3'd7            // 55 bytes before the SFD
`define ETH_PREAMBLE_BYTE  8'h55
`define ETH_SFD            8'hd5
`define ETH_MIN_PAYLOAD    16'd60          // Minimum frame without FCS

// CRC-32
`define ETH_CRC_POLY       32'hedb8_8320   // 04c11db7 bit-reversed
`define ETH_CRC_INIT       32'hffff_ffff
`define ETH_CRC_RESIDUE    32'hc704_dd7b   // Good-frame remainder, normal bit order

// APB register map
`define ETH_REG_STATUS     4'h0
`define ETH_REG_RXCOUNT    4'h4
`define ETH_REG_TXCOUNT    4'h8
`define ETH_REG_CLEAR      4'hc

`endif

// ==== ethRtPkg.sv ====
// Shared types for the real-time Ethernet shim
// All structs are packed with the first member in the MSBs
// Status field layout is the APB status register layout
package ethRtPkg;

    // One GMII lane per direction
    typedef struct packed {
        logic       valid;      // RxValid or TxEn
        logic [7:0] data;       // RxD or TxD
        logic       err;        // RxErr or TxErr
    } gmiiT;

    // Word handed to the receive client
    typedef struct packed {
        logic        ready;     // One-cycle strobe, word valid with it
        logic [15:0] word;      // First byte on the wire in [15:8]
    } recvWordT;

    // Transmit start from the client
    typedef struct packed {
        logic        req;       // One-cycle pulse
        logic [15:0] byteCount; // Payload bytes without FCS
    } sendReqT;

    // APB request and response
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apbRspT;

    // Status register, field view
    typedef struct packed {
        logic [7:0]  reserved;
        logic        crcError;      // Sticky
        logic        recvNotReady;  // Sticky
        logic        txStateError;  // Sticky
        logic        rxOverrun;     // Spare, no FIFO here to overrun
        logic [3:0]  zero;
        logic [15:0] frameTotal;    // Rx plus tx frames
    } statusFieldsT;

    // Same 32 bits seen as the bus word or as fields
    typedef union packed {
        logic [31:0]  raw;
        statusFieldsT fields;
    } statusWordU;

    // One-cycle pulses from the receive framer
    typedef struct packed {
        logic frameDone;
        logic crcBad;           // Only meaningful with frameDone
        logic notReady;         // SFD seen while client not busy
    } rxEventT;

endpackage

// ==== ethCrc32.sv ====
// One byte step of the reflected IEEE 802.3 CRC-32
// Combinational only; the caller owns the running register
// No init or final inversion is applied here
`timescale 1ns/1ps
`include "ethRt_macros.svh"

module ethCrc32 (
    input  logic [7:0]  data,
    input  logic [31:0] crcIn,
    output logic [31:0] crcOut
);

    logic [31:0] stage [0:8];   // Register value after each bit

    // --------------------------------------------------
    // Eight unrolled shift and xor stages, LSB first
    // --------------------------------------------------
    always_comb begin
        stage[0] = crcIn ^ {24'd0, data};   // Byte enters at the LSB end
        for (int i = 0; i < 8; i++) begin
            if (stage[i][0])
                stage[i + 1] = (stage[i] >> 1) ^ `ETH_CRC_POLY;
            else
                stage[i + 1] = stage[i] >> 1;
        end
    end

    assign crcOut = stage[8];

endmodule

// ==== ethRxFramer.sv ====
// GMII receive framer with SFD detect, word packing and FCS check
// Preamble is not checked; any valid d5 byte while idle opens a frame
// Words still carry the four FCS bytes at the end of the frame
// Frame end needs two idle cycles, well inside the 12-byte IPG
`timescale 1ns/1ps
`include "ethRt_macros.svh"

module ethRxFramer (
    input  logic               TxClk,
    input  logic               resetActive,
    input  ethRtPkg::gmiiT     gmiiRx,
    input  logic               recvBusy,
    output logic               recvRequest,
    output ethRtPkg::recvWordT recvWord,
    output ethRtPkg::rxEventT  rxEvent
);

    localparam logic RX_IDLE  = 1'b0;
    localparam logic RX_FRAME = 1'b1;

    logic        rxState;
    logic [15:0] rxBytes;       // Bytes after the SFD, FCS included
    logic        gapCnt;        // Set after the first idle cycle
    logic        accept;        // Client was busy when the SFD came
    logic        errSeen;       // RxErr somewhere in this frame
    logic [31:0] rxCrc;         // Running reflected CRC
    logic [31:0] crcNext;
    logic [31:0] crcNormal;     // rxCrc in normal bit order

    ethCrc32 rxCrcCore (
        .data   (gmiiRx.data),
        .crcIn  (rxCrc),
        .crcOut (crcNext)
    );

    assign crcNormal = {<<{rxCrc}};     // Residue constant is in normal order

    // --------------------------------------------------
    // Receive state machine
    // --------------------------------------------------
    always_ff @(posedge TxClk) begin
        if (resetActive) begin
            rxState        <= RX_IDLE;
            recvRequest    <= 1'b0;
            recvWord.ready <= 1'b0;
            rxEvent        <= '0;
        end else begin
            recvRequest    <= 1'b0;    // All strobes last one cycle
            recvWord.ready <= 1'b0;
            rxEvent        <= '0;
            case (rxState)
                RX_IDLE: begin
                    if (gmiiRx.valid && gmiiRx.data == `ETH_SFD) begin
                        rxState          <= RX_FRAME;
                        recvRequest      <= 1'b1;
                        rxBytes          <= 16'd0;
                        gapCnt           <= 1'b0;
                        accept           <= recvBusy;   // Not busy means drop the frame
                        errSeen          <= 1'b0;
                        rxCrc            <= `ETH_CRC_INIT;
                        rxEvent.notReady <= ~recvBusy;
                    end
                end
                default: begin
                    if (gmiiRx.valid) begin
                        rxBytes <= rxBytes + 16'd1;
                        rxCrc   <= crcNext;             // FCS bytes go through too
                        gapCnt  <= 1'b0;
                        errSeen <= errSeen | gmiiRx.err;
                        if (!rxBytes[0]) begin
                            recvWord.word[15:8] <= gmiiRx.data;     // High byte first
                        end else begin
                            recvWord.word[7:0] <= gmiiRx.data;
                            recvWord.ready     <= accept & recvBusy;
                        end
                    end else if (!gapCnt) begin
                        gapCnt <= 1'b1;                 // First idle cycle
                    end else begin
                        // Second idle cycle closes the frame
                        rxState <= RX_IDLE;
                        if (rxBytes[0]) begin
                            recvWord.word[7:0] <= 8'd0; // Odd length gets a zero pad
                            recvWord.ready     <= accept & recvBusy;
                        end
                        rxEvent.frameDone <= 1'b1;
                        rxEvent.crcBad    <= errSeen | (crcNormal != `ETH_CRC_RESIDUE);
                    end
                end
            endcase
        end
    end

endmodule

// ==== ethTxFramer.sv ====
// GMII transmit framer with preamble, client words, zero pad and FCS
// Client must answer each sendReady with the next word one cycle later
// A byte count of zero sends 60 pad bytes and fetches no words
// Requests that arrive while a frame is going out are ignored
`timescale 1ns/1ps
`include "ethRt_macros.svh"

module ethTxFramer (
    input  logic              TxClk,
    input  logic              resetActive,
    input  ethRtPkg::sendReqT sendReq,
    input  logic [15:0]       sendWord,
    output logic              sendReady,
    output ethRtPkg::gmiiT    gmiiTx,
    output logic              txDone,
    output logic              txStateError
);

    localparam logic [2:0] TX_IDLE     = 3'd0;
    localparam logic [2:0] TX_PREAMBLE = 3'd1;
    localparam logic [2:0] TX_SEND     = 3'd2;
    localparam logic [2:0] TX_PADDING  = 3'd3;
    localparam logic [2:0] TX_CRC      = 3'd4;

    logic [2:0]  txState;
    logic        txEn;
    logic [7:0]  txData;
    logic [2:0]  txCnt;         // Preamble bytes, then FCS bytes
    logic [15:0] sendBytes;     // Requested payload length
    logic [15:0] sendCnt;       // Payload bytes loaded, data plus pad
    logic [31:0] txCrc;         // Running reflected CRC
    logic [31:0] crcNext;
    logic [7:0]  nextByte;      // Byte loaded into TxD at this edge

    // High byte on even counts; pad bytes are zero
    always_comb begin
        if (txState == TX_SEND)
            nextByte = sendCnt[0] ? sendWord[7:0] : sendWord[15:8];
        else
            nextByte = 8'd0;
    end

    ethCrc32 txCrcCore (
        .data   (nextByte),
        .crcIn  (txCrc),
        .crcOut (crcNext)
    );

    assign gmiiTx = '{valid: txEn, data: txData, err: 1'b0};   // TxErr never raised

    // --------------------------------------------------
    // Transmit state machine, all outputs registered
    // --------------------------------------------------
    always_ff @(posedge TxClk) begin
        if (resetActive) begin
            txState      <= TX_IDLE;
            txEn         <= 1'b0;
            sendReady    <= 1'b0;
            txDone       <= 1'b0;
            txStateError <= 1'b0;
        end else begin
            sendReady    <= 1'b0;
            txDone       <= 1'b0;
            txStateError <= 1'b0;
            case (txState)
                TX_IDLE: begin
                    txEn   <= 1'b0;
                    txData <= 8'd0;
                    if (sendReq.req) begin
                        txState   <= TX_PREAMBLE;
                        txEn      <= 1'b1;              // First 55 goes out next cycle
                        txData    <= `ETH_PREAMBLE_BYTE;
                        txCnt     <= 3'd1;
                        sendBytes <= sendReq.byteCount;
                    end
                end
                TX_PREAMBLE: begin
                    if (txCnt == `ETH_PREAMBLE_LEN) begin
                        txData  <= `ETH_SFD;
                        txCrc   <= `ETH_CRC_INIT;       // SFD is outside the CRC
                        sendCnt <= 16'd0;
                        txState <= (sendBytes == 16'd0) ? TX_PADDING : TX_SEND;
                    end else begin
                        txData <= `ETH_PREAMBLE_BYTE;
                        txCnt  <= txCnt + 3'd1;
                        // First word is asked for during the seventh 55
                        sendReady <= (txCnt == `ETH_PREAMBLE_LEN - 3'd1) &&
                                     (sendBytes != 16'd0);
                    end
                end
                TX_SEND: begin
                    txData  <= nextByte;
                    txCrc   <= crcNext;
                    sendCnt <= sendCnt + 16'd1;
                    if (!sendCnt[0])                    // High byte out, fetch next word
                        sendReady <= (sendCnt + 16'd2) < sendBytes;
                    if (sendCnt + 16'd1 == sendBytes) begin
                        txCnt   <= 3'd0;
                        txState <= (sendCnt + 16'd1 < `ETH_MIN_PAYLOAD) ? TX_PADDING : TX_CRC;
                    end
                end
                TX_PADDING: begin
                    txData  <= nextByte;
                    txCrc   <= crcNext;                 // Pad bytes are covered by the FCS
                    sendCnt <= sendCnt + 16'd1;
                    if (sendCnt + 16'd1 == `ETH_MIN_PAYLOAD) begin
                        txCnt   <= 3'd0;
                        txState <= TX_CRC;
                    end
                end
                TX_CRC: begin
                    // Reflected register low byte is the top remainder byte reversed
                    txData <= ~txCrc[7:0];
                    txCrc  <= {8'd0, txCrc[31:8]};
                    txCnt  <= txCnt + 3'd1;
                    if (txCnt == 3'd3) begin
                        txState <= TX_IDLE;             // TxEn drops on the next edge
                        txDone  <= 1'b1;
                    end
                end
                default: begin
                    // Unused encodings 5 to 7
                    txStateError <= 1'b1;
                    txEn         <= 1'b0;
                    txState      <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== ethRtStatus.sv ====
// APB status block with frame counters and sticky error flags
// No wait states and no slave errors
// Any write to the clear address zeroes everything, write data ignored
// Counters are 16 bits and wrap
`timescale 1ns/1ps
`include "ethRt_macros.svh"

module ethRtStatus (
    input  logic              TxClk,
    input  logic              resetActive,
    input  ethRtPkg::apbReqT  apbReq,
    output ethRtPkg::apbRspT  apbRsp,
    input  ethRtPkg::rxEventT rxEvent,
    input  logic              txDone,
    input  logic              txStateError
);

    import ethRtPkg::*;

    logic [15:0] rxCount;       // Frames closed by the receive framer
    logic [15:0] txCount;       // Frames fully sent
    logic        crcErrorFlag;
    logic        notReadyFlag;
    logic        txErrorFlag;
    logic        clearHit;      // Access phase of a write to the clear register
    logic [31:0] rdData;
    statusWordU  statusWord;

    assign clearHit = apbReq.psel & apbReq.penable & apbReq.pwrite &
                      (apbReq.paddr == `ETH_REG_CLEAR);

    // --------------------------------------------------
    // Counters and sticky flags
    // --------------------------------------------------
    always_ff @(posedge TxClk) begin
        if (resetActive || clearHit) begin
            rxCount      <= 16'd0;
            txCount      <= 16'd0;
            crcErrorFlag <= 1'b0;
            notReadyFlag <= 1'b0;
            txErrorFlag  <= 1'b0;
        end else begin
            if (rxEvent.frameDone)
                rxCount <= rxCount + 16'd1;
            if (txDone)
                txCount <= txCount + 16'd1;
            if (rxEvent.frameDone && rxEvent.crcBad)
                crcErrorFlag <= 1'b1;
            if (rxEvent.notReady)
                notReadyFlag <= 1'b1;       // Set at SFD time
            if (txStateError)
                txErrorFlag <= 1'b1;
        end
    end

    // Status word built in the field view
    always_comb begin
        statusWord.fields.reserved     = 8'd0;
        statusWord.fields.crcError     = crcErrorFlag;
        statusWord.fields.recvNotReady = notReadyFlag;
        statusWord.fields.txStateError = txErrorFlag;
        statusWord.fields.rxOverrun    = 1'b0;
        statusWord.fields.zero         = 4'd0;
        statusWord.fields.frameTotal   = rxCount + txCount;
    end

    // Read mux, valid in the access cycle
    always_comb begin
        case (apbReq.paddr)
            `ETH_REG_STATUS:  rdData = statusWord.raw;
            `ETH_REG_RXCOUNT: rdData = {16'd0, rxCount};
            `ETH_REG_TXCOUNT: rdData = {16'd0, txCount};
            default:          rdData = 32'd0;       // Clear register reads zero
        endcase
    end

    assign apbRsp = '{pready: 1'b1, pslverr: 1'b0, prdata: rdData};

endmodule

// ==== ethRtInterface.sv ====
// Real-time Ethernet shim between a GMII port and a 16-bit word client
// Single clock domain; RxClk is TxClk forwarded to the PHY
// No address filtering and no FIFO, so the client keeps pace with the wire
// TxErr is held low by the transmit framer
`timescale 1ns/1ps

module ethRtInterface (
    input  logic               TxClk,
    input  logic               resetActive,
    output logic               RxClk,
    input  ethRtPkg::gmiiT     gmiiRx,
    output ethRtPkg::gmiiT     gmiiTx,
    input  logic               recvBusy,
    output logic               recvRequest,
    output ethRtPkg::recvWordT recvWord,
    input  ethRtPkg::sendReqT  sendReq,
    input  logic [15:0]        sendWord,
    output logic               sendReady,
    input  ethRtPkg::apbReqT   apbReq,
    output ethRtPkg::apbRspT   apbRsp
);

    import ethRtPkg::*;

    rxEventT rxEvent;           // Receive pulses to the status block
    logic    txDone;
    logic    txStateError;

    assign RxClk = TxClk;

    // --------------------------------------------------
    // Receive and transmit framers
    // --------------------------------------------------
    ethRxFramer rxFramer (
        .TxClk       (TxClk),
        .resetActive (resetActive),
        .gmiiRx      (gmiiRx),
        .recvBusy    (recvBusy),
        .recvRequest (recvRequest),
        .recvWord    (recvWord),
        .rxEvent     (rxEvent)
    );

    ethTxFramer txFramer (
        .TxClk        (TxClk),
        .resetActive  (resetActive),
        .sendReq      (sendReq),
        .sendWord     (sendWord),
        .sendReady    (sendReady),
        .gmiiTx       (gmiiTx),
        .txDone       (txDone),
        .txStateError (txStateError)
    );

    // Counters and flags on APB
    ethRtStatus status (
        .TxClk        (TxClk),
        .resetActive  (resetActive),
        .apbReq       (apbReq),
        .apbRsp       (apbRsp),
        .rxEvent      (rxEvent),
        .txDone       (txDone),
        .txStateError (txStateError)
    );

endmodule

// ==== ethRtInterface_checker.sv ====
// Concurrent checks on GMII framing and the receive handshake
// Assumes a new transmit request only while TxEn is low
// Each failure also bumps failCount, which the testbench adds to its totals
`timescale 1ns/1ps
`include "ethRt_macros.svh"

module ethRtInterfaceChecker (
    input logic               TxClk,
    input logic               resetActive,
    input ethRtPkg::gmiiT     gmiiTx,
    input ethRtPkg::gmiiT     gmiiRx,
    input ethRtPkg::sendReqT  sendReq,
    input logic               recvBusy,
    input logic               recvRequest,
    input ethRtPkg::recvWordT recvWord
);

    int          failCount = 0;
    logic [15:0] txPos;         // TxEn-high cycles so far in this frame
    logic [15:0] expLen;        // 8 + max(n,60) + 4

    always_ff @(posedge TxClk) begin
        if (resetActive || !gmiiTx.valid)
            txPos <= 16'd0;
        else
            txPos <= txPos + 16'd1;
    end

    always_ff @(posedge TxClk) begin
        if (resetActive)
            expLen <= 16'd0;
        else if (sendReq.req && !gmiiTx.valid)
            expLen <= 16'd12 + ((sendReq.byteCount < `ETH_MIN_PAYLOAD) ?
                                `ETH_MIN_PAYLOAD : sendReq.byteCount);
    end

    // --------------------------------------------------
    // Transmit framing
    // --------------------------------------------------
    txStart: assert property (@(posedge TxClk) disable iff (resetActive)
        sendReq.req && !gmiiTx.valid |=> $rose(gmiiTx.valid))
        else begin failCount++; $error("TxEn did not rise after a request"); end

    txPreamble: assert property (@(posedge TxClk) disable iff (resetActive)
        gmiiTx.valid && txPos < 16'd7 |-> gmiiTx.data == `ETH_PREAMBLE_BYTE)
        else begin failCount++; $error("Preamble byte is wrong"); end

    txSfd: assert property (@(posedge TxClk) disable iff (resetActive)
        gmiiTx.valid && txPos == 16'd7 |-> gmiiTx.data == `ETH_SFD)
        else begin failCount++; $error("SFD missing after seven preamble bytes"); end

    txLength: assert property (@(posedge TxClk) disable iff (resetActive)
        $fell(gmiiTx.valid) |-> txPos == expLen)
        else begin failCount++; $error("TxEn high for the wrong number of cycles"); end

    txErrLow: assert property (@(posedge TxClk) disable iff (resetActive)
        !gmiiTx.err)
        else begin failCount++; $error("TxErr raised"); end

    // --------------------------------------------------
    // Receive handshake
    // --------------------------------------------------
    rxStart: assert property (@(posedge TxClk) disable iff (resetActive)
        recvRequest |-> $past(gmiiRx.valid && gmiiRx.data == `ETH_SFD))
        else begin failCount++; $error("recvRequest without an SFD"); end

    rxBusy: assert property (@(posedge TxClk) disable iff (resetActive)
        recvWord.ready |-> $past(recvBusy))
        else begin failCount++; $error("Word delivered while client not busy"); end

    resetLow: assert property (@(posedge TxClk) disable iff (resetActive)
        $fell(resetActive) |-> !gmiiTx.valid && !recvRequest && !recvWord.ready)
        else begin failCount++; $error("Strobe high right after reset"); end

endmodule

bind ethRtInterface ethRtInterfaceChecker frameCheck (
    .TxClk       (TxClk),
    .resetActive (resetActive),
    .gmiiTx      (gmiiTx),
    .gmiiRx      (gmiiRx),
    .sendReq     (sendReq),
    .recvBusy    (recvBusy),
    .recvRequest (recvRequest),
    .recvWord    (recvWord)
);

// ==== ethRtInterfaceTb.sv ====
// Testbench for the real-time Ethernet shim
// GMII transmit is looped back to receive, with an optional single bit flip
// Send words come from a seeded xorshift source, so every run is the same
// New requests are only issued once the previous frame has closed
`timescale 1ns/1ps
`include "ethRt_macros.svh"

module ethRtInterfaceTb;

    import ethRtPkg::*;

    localparam int TIMEOUT = 400;       // Cycles allowed per wait

    logic        TxClk;
    logic        resetActive;
    logic        RxClk;
    gmiiT        gmiiRx;
    gmiiT        gmiiTx;
    logic        recvBusy;
    logic        recvRequest;
    recvWordT    recvWord;
    sendReqT     sendReq;
    logic [15:0] sendWord;
    logic        sendReady;
    apbReqT      apbReq;
    apbRspT      apbRsp;

    logic [7:0]  flipMask;              // Bit error put on the loopback
    logic [31:0] rngState;
    logic        readySeen;             // sendReady seen in the last cycle
    logic        prevValid;
    logic [15:0] sentWords [$];         // Words handed to the transmitter
    logic [15:0] gotWords [$];          // Words from the receive side
    logic [31:0] rdData;
    int          requestCount;
    int          cycleCount;
    int          fallCycle;             // Cycle where RxValid fell
    int          lastReadyCycle;
    int          errCount;
    int          timeoutCount;

    ethRtInterface uut (
        .TxClk       (TxClk),
        .resetActive (resetActive),
        .RxClk       (RxClk),
        .gmiiRx      (gmiiRx),
        .gmiiTx      (gmiiTx),
        .recvBusy    (recvBusy),
        .recvRequest (recvRequest),
        .recvWord    (recvWord),
        .sendReq     (sendReq),
        .sendWord    (sendWord),
        .sendReady   (sendReady),
        .apbReq      (apbReq),
        .apbRsp      (apbRsp)
    );

    assign gmiiRx = '{valid: gmiiTx.valid, data: gmiiTx.data ^ flipMask, err: gmiiTx.err};

    initial TxClk = 1'b0;
    always #2 TxClk = ~TxClk;           // 4 ns period

    // --------------------------------------------------
    // Client models
    // --------------------------------------------------
    always @(negedge TxClk)
        readySeen = sendReady;

    // Next word goes out 1 ns after the edge that ends the sendReady pulse
    always @(posedge TxClk) begin
        #1;
        if (readySeen) begin
            rngState = xorshift32(rngState);
            sendWord = rngState[15:0];
            sentWords.push_back(rngState[15:0]);
        end
    end

    // Receive client and RxValid watch, sampled mid-cycle
    always @(negedge TxClk) begin
        cycleCount++;
        if (recvWord.ready) begin
            gotWords.push_back(recvWord.word);
            lastReadyCycle = cycleCount;
        end
        if (recvRequest)
            requestCount++;
        if (prevValid && !gmiiRx.valid)
            fallCycle = cycleCount;
        prevValid = gmiiRx.valid;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Bit-serial reflected CRC-32, feedback taken per input bit
    function automatic logic [31:0] crcStep(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            fb = c[0] ^ b[k];
            c  = {1'b0, c[31:1]} ^ (fb ? `ETH_CRC_POLY : 32'd0);
        end
        return c;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got == exp) else begin
            errCount++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge TxClk);
        #1;
    endtask

    task automatic waitTxEn(input logic level);
        int n;
        n = 0;
        while (gmiiTx.valid !== level && n < TIMEOUT) begin
            waitCycles(1);
            n++;
        end
        if (gmiiTx.valid !== level) begin
            timeoutCount++;
            $display("timeout: TxEn did not go to %0d within %0d cycles", level, TIMEOUT);
        end
    endtask

    // --------------------------------------------------
    // Frame and APB tasks
    // --------------------------------------------------
    task automatic runFrame(input int n, input logic busy, input logic corrupt);
        sentWords.delete();
        gotWords.delete();
        requestCount = 0;
        recvBusy     = busy;
        sendReq      = '{req: 1'b1, byteCount: n[15:0]};
        waitCycles(1);
        sendReq.req = 1'b0;
        waitTxEn(1'b1);
        if (corrupt) begin
            waitCycles(20);             // Lands inside the payload
            flipMask = 8'h04;
            waitCycles(1);
            flipMask = 8'h00;
        end
        waitTxEn(1'b0);
        waitCycles(4);                  // Frame closes 2 cycles after RxValid falls
        recvBusy = 1'b1;
    endtask

    // Wire bytes after the SFD, packed two per word
    task automatic checkFrame(input int n);
        logic [7:0]  bytes [$];
        logic [31:0] crc;
        logic [15:0] expWord;
        int          i;
        checkValue("sentWords.size", sentWords.size(), (n + 1) / 2);
        checkValue("recvRequest count", requestCount, 32'd1);
        for (i = 0; i < n && i / 2 < sentWords.size(); i++)
            bytes.push_back(i[0] ? sentWords[i / 2][7:0] : sentWords[i / 2][15:8]);
        while (bytes.size() < 60)
            bytes.push_back(8'h00);     // Zero pad
        crc = `ETH_CRC_INIT;
        for (i = 0; i < bytes.size(); i++)
            crc = crcStep(crc, bytes[i]);
        crc = ~crc;
        for (i = 0; i < 4; i++)
            bytes.push_back(crc[8 * i +: 8]);   // FCS low byte first
        checkValue("gotWords.size", gotWords.size(), (bytes.size() + 1) / 2);
        for (i = 0; i < gotWords.size() && 2 * i < bytes.size(); i++) begin
            expWord[15:8] = bytes[2 * i];
            if (2 * i + 1 < bytes.size())
                expWord[7:0] = bytes[2 * i + 1];
            else
                expWord[7:0] = 8'h00;
            checkValue("recvWord.word", {16'd0, gotWords[i]}, {16'd0, expWord});
        end
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data);
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        waitCycles(1);
        apbReq.penable = 1'b1;          // Access cycle
        #2;
        data = apbRsp.prdata;
        checkValue("apbRsp.pready", {31'd0, apbRsp.pready}, 32'd1);
        checkValue("apbRsp.pslverr", {31'd0, apbRsp.pslverr}, 32'd0);
        waitCycles(1);
        apbReq = '0;
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data);
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        waitCycles(1);
        apbReq.penable = 1'b1;
        waitCycles(1);
        apbReq = '0;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        resetActive    = 1'b1;
        recvBusy       = 1'b1;
        sendReq        = '0;
        sendWord       = 16'd0;
        apbReq         = '0;
        flipMask       = 8'h00;
        rngState       = 32'hc983_b810;
        readySeen      = 1'b0;
        prevValid      = 1'b0;
        requestCount   = 0;
        cycleCount     = 0;
        fallCycle      = 0;
        lastReadyCycle = 0;
        errCount       = 0;
        timeoutCount   = 0;
        repeat (3) @(posedge TxClk);
        #1;
        resetActive = 1'b0;
        checkValue("RxClk", {31'd0, RxClk}, 32'd1);     // Mid high phase
        #2;
        checkValue("RxClk", {31'd0, RxClk}, 32'd0);     // Mid low phase
        waitCycles(2);

        runFrame(10, 1'b1, 1'b0);       // Short, padded to 60
        checkFrame(10);
        runFrame(60, 1'b1, 1'b0);
        checkFrame(60);
        runFrame(64, 1'b1, 1'b0);
        checkFrame(64);
        runFrame(61, 1'b1, 1'b0);       // Odd length, last word half padded
        checkFrame(61);
        checkValue("odd word delay", lastReadyCycle - fallCycle, 32'd2);
        apbRead(`ETH_REG_STATUS, rdData);
        checkValue("status", rdData, 32'h0000_0008);    // Four rx, four tx, no flags

        runFrame(20, 1'b1, 1'b1);       // One flipped bit
        apbRead(`ETH_REG_STATUS, rdData);
        checkValue("status", rdData, 32'h0080_000a);

        runFrame(30, 1'b0, 1'b0);       // Client not busy at the SFD
        checkValue("gotWords.size", gotWords.size(), 32'd0);
        checkValue("recvRequest count", requestCount, 32'd1);
        apbRead(`ETH_REG_STATUS, rdData);
        checkValue("status", rdData, 32'h00c0_000c);
        apbRead(`ETH_REG_RXCOUNT, rdData);
        checkValue("rxCount", rdData, 32'd6);
        apbRead(`ETH_REG_TXCOUNT, rdData);
        checkValue("txCount", rdData, 32'd6);

        apbWrite(`ETH_REG_CLEAR, 32'd0);
        apbRead(`ETH_REG_STATUS, rdData);
        checkValue("status", rdData, 32'd0);
        apbRead(`ETH_REG_RXCOUNT, rdData);
        checkValue("rxCount", rdData, 32'd0);

        $display("errors: %0d checks, %0d timeouts, %0d assertions",
                 errCount, timeoutCount, uut.frameCheck.failCount);
        if (errCount + timeoutCount + uut.frameCheck.failCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
ethRtPkg.sv
ethCrc32.sv
ethRxFramer.sv
ethTxFramer.sv
ethRtStatus.sv
ethRtInterface.sv
ethRtInterface_checker.sv
ethRtInterfaceTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the shim testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert -f files.f --top-module ethRtInterfaceTb \
    -Mdir obj_dir -o simv

./obj_dir/simv +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished, see sim.log"
